// ==== core_backend.f ====
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/pipe_reg.sv
logic/alu_exec.sv
logic/hazard_ctrl.sv
logic/core_backend.sv
verif/core_backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core_backend testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module core_backend_tb \
    -f core_backend.f -o core_backend_sim
./obj_dir/core_backend_sim > sim.log 2>&1
cat sim.log
if grep -qx '=== PASS ===' sim.log; then
    exit 0
fi
echo "simulation reported failure, see sim.log"
exit 1

// ==== verif/core_backend_tb.sv ====
`timescale 1ns/1ps

module core_backend_tb
    import rv_isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int PROG_LEN       = 96;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 10 + 200;
    localparam logic [XLEN-1:0] PROG_END = XLEN'(PROG_LEN * 4);
    localparam logic [6:0] OPC_CUSTOM = 7'b0001011;  // custom-0, not decoded by the core

    logic            clk = 1'b0;
    logic            arst;
    fetch_t          fetch;
    logic            fetch_valid;
    logic            fetch_ready;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    retire_t         retire;
    logic            retire_valid;
    logic            retire_ready;

    logic [31:0]     lcg_state = 32'h5f24;
    logic [31:0]     prog_mem [PROG_LEN];
    retire_t         want_retire [$];
    logic [XLEN-1:0] want_redirect [$];
    logic [XLEN-1:0] fetch_pc;
    retire_t         held_rec;
    logic            hold_pending;
    int              model_retires = 0;
    int              model_redirects = 0;
    int              retire_count = 0;
    int              redirect_count = 0;
    int              error_count = 0;
    int              cycle_count = 0;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    core_backend core_backend_i (
        .i_clk            (clk),
        .i_arst           (arst),
        .i_fetch          (fetch),
        .i_fetch_valid    (fetch_valid),
        .o_fetch_ready    (fetch_ready),
        .o_redirect_valid (redirect_valid),
        .o_redirect_pc    (redirect_pc),
        .o_retire         (retire),
        .o_retire_valid   (retire_valid),
        .i_retire_ready   (retire_ready)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (lcg_next() >> 16) % n;  // upper bits have the longer period
    endfunction

    // ########################################
    // program generator and ISA model
    // ########################################
    task automatic generate_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        int unsigned kind;
        for (int k = 0; k < PROG_LEN; k++) begin
            rd    = 5'(rand_below(8));  // x0..x7 keeps dependencies dense
            rs1   = 5'(rand_below(8));
            rs2   = 5'(rand_below(8));
            f3    = 3'(rand_below(8));
            imm12 = 12'(lcg_next() >> 20);
            kind  = rand_below(16);
            if (kind < 5) begin
                f7 = 7'b0;
                if ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) begin
                    f7 = 7'b0100000;  // sub or sra
                end
                prog_mem[k] = {f7, rs2, rs1, f3, rd, OPC_OP};
            end else if (kind < 10) begin
                if (f3 == 3'd1) begin
                    imm12 = {6'b0, imm12[5:0]};
                end else if (f3 == 3'd5) begin
                    imm12 = {1'b0, 1'(rand_below(2)), 4'b0, imm12[5:0]};  // bit 30 picks srai
                end
                prog_mem[k] = {imm12, rs1, f3, rd, OPC_OP_IMM};
            end else if (kind == 10) begin
                prog_mem[k] = {20'(lcg_next() >> 12), rd, OPC_LUI};
            end else if (kind == 11) begin
                joff = 21'(4 * (1 + rand_below(4)));  // forward only
                prog_mem[k] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
            end else if (kind < 15) begin
                boff = 13'(4 * (1 + rand_below(6)));
                case (rand_below(4))
                    0:       f3 = F3_BEQ;
                    1:       f3 = F3_BNE;
                    2:       f3 = F3_BLT;
                    default: f3 = F3_BGE;
                endcase
                prog_mem[k] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
                               OPC_BRANCH};
            end else begin
                prog_mem[k] = {25'(lcg_next() >> 7), OPC_CUSTOM};
            end
        end
    endtask

    function automatic logic [XLEN-1:0] isa_alu(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [5:0] sh;
        sh = b[5:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return XLEN'($signed(a) < $signed(b));
            3'd3: return XLEN'(a < b);
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        logic [XLEN-1:0] regs [32];
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] target;
        logic [31:0]     ins;
        logic [2:0]      f3;
        logic            taken;
        retire_t         rec;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc = '0;
        while (pc < PROG_END) begin
            ins    = prog_mem[int'(pc >> 2)];
            f3     = ins[14:12];
            a      = regs[ins[19:15]];
            b      = regs[ins[24:20]];
            taken  = 1'b0;
            target = '0;
            rec    = '0;
            rec.pc = pc;
            rec.rd = ins[11:7];
            case (ins[6:0])
                OPC_OP: begin
                    rec.wdata = isa_alu(f3, ins[30], a, b);
                    rec.we    = 1'b1;
                end
                OPC_OP_IMM: begin
                    rec.wdata = isa_alu(f3, (f3 == 3'd5) && ins[30], a,
                                        {{52{ins[31]}}, ins[31:20]});
                    rec.we    = 1'b1;
                end
                OPC_LUI: begin
                    rec.wdata = {{32{ins[31]}}, ins[31:12], 12'b0};
                    rec.we    = 1'b1;
                end
                OPC_JAL: begin
                    rec.wdata = pc + 64'd4;
                    rec.we    = 1'b1;
                    taken     = 1'b1;
                    target    = pc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20],
                                      ins[30:21], 1'b0};
                end
                OPC_BRANCH: begin
                    case (f3)
                        3'd0:    taken = (a == b);
                        3'd1:    taken = (a != b);
                        3'd4:    taken = ($signed(a) < $signed(b));
                        default: taken = ($signed(a) >= $signed(b));  // bge
                    endcase
                    target = pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                default: ;  // unknown opcode retires without a write
            endcase
            if (rec.rd == 5'd0) begin
                rec.we = 1'b0;
            end
            if (rec.we) begin
                regs[rec.rd] = rec.wdata;
            end
            want_retire.push_back(rec);
            if (taken) begin
                want_redirect.push_back(target);
                pc = target;
            end else begin
                pc = pc + 64'd4;
            end
        end
        model_retires   = want_retire.size();
        model_redirects = want_redirect.size();
    endtask

    // ########################################
    // checks
    // ########################################
    task automatic check_equal(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        assert (got == want) else begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_idle();
        check_equal("o_retire_valid", XLEN'(retire_valid), '0);
        check_equal("o_redirect_valid", XLEN'(redirect_valid), '0);
        check_equal("o_fetch_ready", XLEN'(fetch_ready), XLEN'(1'b1));
    endtask

    task automatic check_retire();
        retire_t want;
        assert (want_retire.size() > 0) else begin
            error_count++;
            $display("retire of pc %h at %0t with no instruction left in the model",
                     retire.pc, $time);
        end
        if (want_retire.size() > 0) begin
            want = want_retire.pop_front();
            check_equal("o_retire.pc", retire.pc, want.pc);
            check_equal("o_retire.rd", XLEN'(retire.rd), XLEN'(want.rd));
            check_equal("o_retire.we", XLEN'(retire.we), XLEN'(want.we));
            if (want.we) begin
                check_equal("o_retire.wdata", retire.wdata, want.wdata);
            end
        end
        retire_count++;
    endtask

    task automatic observe_ports();
        if (hold_pending) begin
            check_equal("o_retire_valid", XLEN'(retire_valid), XLEN'(1'b1));
            assert (retire == held_rec) else begin
                error_count++;
                $display("CHECK FAILED at %0t: o_retire got %h expected %h",
                         $time, retire, held_rec);
            end
        end
        hold_pending = retire_valid && !retire_ready;
        held_rec     = retire;
        if (retire_valid && retire_ready) begin
            check_retire();
        end
        if (redirect_valid) begin
            check_equal("o_fetch_ready", XLEN'(fetch_ready), '0);
            assert (want_redirect.size() > 0) else begin
                error_count++;
                $display("redirect to %h at %0t with no taken branch left in the model",
                         redirect_pc, $time);
            end
            if (want_redirect.size() > 0) begin
                check_equal("o_redirect_pc", redirect_pc, want_redirect.pop_front());
            end
            redirect_count++;
            fetch_pc = redirect_pc;
        end else if (fetch_valid && fetch_ready) begin
            fetch_pc = fetch_pc + 64'd4;
        end
    endtask

    // ########################################
    // fetch driver and run control
    // ########################################
    task automatic drive_cycle();
        @(negedge clk);
        fetch.pc = fetch_pc;
        if (fetch_pc < PROG_END && rand_below(4) != 0) begin
            fetch_valid = 1'b1;
            fetch.instr = prog_mem[int'(fetch_pc >> 2)];
        end else begin
            fetch_valid = 1'b0;
            fetch.instr = lcg_next();  // junk while idle
        end
        retire_ready = (rand_below(3) != 0);
        #1;  // outputs now hold up to the next rising edge
        observe_ports();
    endtask

    task automatic finish_run();
        $display("retired %0d of %0d, redirects %0d of %0d, errors %0d",
                 retire_count, model_retires, redirect_count, model_redirects, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        arst         = 1'b1;
        fetch        = '0;
        fetch_valid  = 1'b0;
        retire_ready = 1'b0;
        fetch_pc     = '0;
        hold_pending = 1'b0;
        held_rec     = '0;
        generate_program();
        run_model();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle();
        end
        arst = 1'b0;
        #1;
        check_idle();
        while (want_retire.size() > 0) begin
            drive_cycle();
        end
        repeat (8) begin
            drive_cycle();  // nothing may retire from here on
        end
        assert (retire_count == model_retires) else begin
            error_count++;
            $display("%0d instructions retired but the model executed %0d",
                     retire_count, model_retires);
        end
        assert (want_redirect.size() == 0) else begin
            error_count++;
            $display("%0d taken branches never redirected the fetch side",
                     want_redirect.size());
        end
        finish_run();
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        error_count++;
        $display("timeout after %0d cycles with %0d instructions never retired",
                 cycle_count, want_retire.size());
        finish_run();
    end

endmodule

// ==== logic/core_backend.sv ====
`timescale 1ns/1ps

module core_backend
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_arst,
    input  fetch_t          i_fetch,
    input  logic            i_fetch_valid,
    output logic            o_fetch_ready,
    output logic            o_redirect_valid,
    output logic [XLEN-1:0] o_redirect_pc,
    output retire_t         o_retire,
    output logic            o_retire_valid,
    input  logic            i_retire_ready
);

    dec_exec_t       dec;
    dec_exec_t       ex;
    logic            dec_valid;
    logic            ex_valid;
    logic            stall;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    retire_t         ex_result;
    logic            ex_taken;
    logic [XLEN-1:0] ex_target;
    logic            ret_we;

    instr_decoder decoder_i (
        .i_fetch (i_fetch),
        .i_valid (dec_valid),
        .o_dec   (dec)
    );

    // ########################################
    // decode to execute
    // ########################################
    pipe_reg #(.payload_t(dec_exec_t)) idex_reg (
        .i_clk   (i_clk),
        .i_arst  (i_arst),
        .i_stall (stall),
        .i_valid (dec_valid),
        .i_data  (dec),
        .o_valid (ex_valid),
        .o_data  (ex)
    );

    reg_file reg_file_i (
        .i_clk      (i_clk),
        .i_arst     (i_arst),
        .i_rs1_addr (ex.rs1_addr),
        .i_rs2_addr (ex.rs2_addr),
        .i_we       (ret_we),
        .i_rd_addr  (o_retire.rd),
        .i_wdata    (o_retire.wdata),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    alu_exec alu_exec_i (
        .i_dec    (ex),
        .i_op_a   (op_a),
        .i_op_b   (op_b),
        .o_result (ex_result),
        .o_taken  (ex_taken),
        .o_target (ex_target)
    );

    hazard_ctrl hazard_ctrl_i (
        .i_fetch_valid    (i_fetch_valid),
        .i_ex_valid       (ex_valid),
        .i_ex_taken       (ex_taken),
        .i_ex_target      (ex_target),
        .i_rs1_addr       (ex.rs1_addr),
        .i_rs2_addr       (ex.rs2_addr),
        .i_rs1_data       (rs1_data),
        .i_rs2_data       (rs2_data),
        .i_ret_valid      (o_retire_valid),
        .i_ret            (o_retire),
        .i_retire_ready   (i_retire_ready),
        .o_stall          (stall),
        .o_fetch_ready    (o_fetch_ready),
        .o_dec_valid      (dec_valid),
        .o_redirect_valid (o_redirect_valid),
        .o_redirect_pc    (o_redirect_pc),
        .o_op_a           (op_a),
        .o_op_b           (op_b),
        .o_ret_we         (ret_we)
    );

    // ########################################
    // execute to retire
    // ########################################
    pipe_reg #(.payload_t(retire_t)) retire_reg (
        .i_clk   (i_clk),
        .i_arst  (i_arst),
        .i_stall (stall),
        .i_valid (ex_valid),
        .i_data  (ex_result),
        .o_valid (o_retire_valid),
        .o_data  (o_retire)
    );

endmodule

// ==== logic/hazard_ctrl.sv ====
`timescale 1ns/1ps

module hazard_ctrl
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            i_fetch_valid,
    input  logic            i_ex_valid,
    input  logic            i_ex_taken,
    input  logic [XLEN-1:0] i_ex_target,
    input  logic [4:0]      i_rs1_addr,
    input  logic [4:0]      i_rs2_addr,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_rs2_data,
    input  logic            i_ret_valid,
    input  retire_t         i_ret,
    input  logic            i_retire_ready,
    output logic            o_stall,
    output logic            o_fetch_ready,
    output logic            o_dec_valid,
    output logic            o_redirect_valid,
    output logic [XLEN-1:0] o_redirect_pc,
    output logic [XLEN-1:0] o_op_a,
    output logic [XLEN-1:0] o_op_b,
    output logic            o_ret_we
);

    logic fwd_a;
    logic fwd_b;

    assign o_stall          = i_ret_valid && !i_retire_ready;
    assign o_redirect_valid = i_ex_valid && i_ex_taken && !o_stall;
    assign o_redirect_pc    = i_ex_target;
    assign o_fetch_ready    = !o_stall && !o_redirect_valid;  // squashes the younger item
    assign o_dec_valid      = i_fetch_valid && o_fetch_ready;

    // the retire record is the only result not yet in the register file
    assign fwd_a  = i_ret_valid && i_ret.we && (i_ret.rd == i_rs1_addr);
    assign fwd_b  = i_ret_valid && i_ret.we && (i_ret.rd == i_rs2_addr);
    assign o_op_a = fwd_a ? i_ret.wdata : i_rs1_data;
    assign o_op_b = fwd_b ? i_ret.wdata : i_rs2_data;

    assign o_ret_we = i_ret_valid && i_retire_ready && i_ret.we;

endmodule

// ==== logic/alu_exec.sv ====
`timescale 1ns/1ps

module alu_exec
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  dec_exec_t       i_dec,
    input  logic [XLEN-1:0] i_op_a,
    input  logic [XLEN-1:0] i_op_b,
    output retire_t         o_result,
    output logic            o_taken,
    output logic [XLEN-1:0] o_target
);

    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] alu_res;
    logic            br_eq;
    logic            br_lt;
    logic            cond_met;

    assign op_b  = i_dec.alu_src_imm ? i_dec.imm : i_op_b;
    assign shamt = op_b[5:0];  // rv64 shifts use six bits

    always_comb begin
        case (i_dec.alu_op)
            ALU_ADD:      alu_res = i_op_a + op_b;
            ALU_SUB:      alu_res = i_op_a - op_b;
            ALU_AND:      alu_res = i_op_a & op_b;
            ALU_OR:       alu_res = i_op_a | op_b;
            ALU_XOR:      alu_res = i_op_a ^ op_b;
            ALU_SLT:      alu_res = {{(XLEN-1){1'b0}}, $signed(i_op_a) < $signed(op_b)};
            ALU_SLTU:     alu_res = {{(XLEN-1){1'b0}}, i_op_a < op_b};
            ALU_SLL:      alu_res = i_op_a << shamt;
            ALU_SRL:      alu_res = i_op_a >> shamt;
            ALU_SRA:      alu_res = $signed(i_op_a) >>> shamt;
            ALU_PASS_IMM: alu_res = i_dec.imm;
            default:      alu_res = '0;
        endcase
    end

    // ########################################
    // branch and jump
    // ########################################
    assign br_eq = (i_op_a == i_op_b);
    assign br_lt = ($signed(i_op_a) < $signed(i_op_b));

    always_comb begin
        case (i_dec.br_cond)
            BR_EQ:   cond_met = br_eq;
            BR_NE:   cond_met = !br_eq;
            BR_LT:   cond_met = br_lt;
            BR_GE:   cond_met = !br_lt;
            default: cond_met = 1'b0;
        endcase
    end

    assign o_taken  = i_dec.is_jump || cond_met;
    assign o_target = i_dec.pc + i_dec.imm;

    assign o_result.pc    = i_dec.pc;
    assign o_result.rd    = i_dec.rd_addr;
    assign o_result.wdata = i_dec.is_jump ? i_dec.pc + XLEN'(4) : alu_res;  // jal links pc+4
    assign o_result.we    = i_dec.reg_we;

endmodule

// ==== logic/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_arst,
    input  logic     i_stall,
    input  logic     i_valid,
    input  payload_t i_data,
    output logic     o_valid,
    output payload_t o_data
);

    always_ff @(posedge i_clk, posedge i_arst) begin
        if (i_arst) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else if (!i_stall) begin
            o_valid <= i_valid;
            o_data  <= i_valid ? i_data : '0;  // a bubble carries an all-zero payload
        end
    end

    // a stalled stage must present the same record on the next cycle
    a_hold_on_stall: assert property (@(posedge i_clk) disable iff (i_arst)
        i_stall |=> ($stable(o_valid) && $stable(o_data)));

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import rv_isa_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_arst,
    input  logic [4:0]      i_rs1_addr,
    input  logic [4:0]      i_rs2_addr,
    input  logic            i_we,
    input  logic [4:0]      i_rd_addr,
    input  logic [XLEN-1:0] i_wdata,
    output logic [XLEN-1:0] o_rs1_data,
    output logic [XLEN-1:0] o_rs2_data
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge i_clk, posedge i_arst) begin
        if (i_arst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_wdata;  // x0 is never written
        end
    end

    assign o_rs1_data = regs[i_rs1_addr];
    assign o_rs2_data = regs[i_rs2_addr];

    // x0 must read as zero through any sequence of writes
    a_x0_rs1: assert property (@(posedge i_clk) disable iff (i_arst)
        (i_rs1_addr == '0) |-> (o_rs1_data == '0));
    a_x0_rs2: assert property (@(posedge i_clk) disable iff (i_arst)
        (i_rs2_addr == '0) |-> (o_rs2_data == '0));

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  fetch_t    i_fetch,
    input  logic      i_valid,
    output dec_exec_t o_dec
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    assign opcode = i_fetch.instr[6:0];
    assign funct3 = i_fetch.instr[14:12];
    assign rd     = i_fetch.instr[11:7];

    assign imm_i = XLEN'($signed(i_fetch.instr[31:20]));
    assign imm_u = XLEN'($signed({i_fetch.instr[31:12], 12'b0}));
    assign imm_b = XLEN'($signed({i_fetch.instr[31], i_fetch.instr[7],
                                  i_fetch.instr[30:25], i_fetch.instr[11:8], 1'b0}));
    assign imm_j = XLEN'($signed({i_fetch.instr[31], i_fetch.instr[19:12],
                                  i_fetch.instr[20], i_fetch.instr[30:21], 1'b0}));

    // alt selects sub or sra, taken from instr bit 30
    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    always_comb begin
        o_dec          = '0;
        o_dec.pc       = i_fetch.pc;
        o_dec.rs1_addr = i_fetch.instr[19:15];
        o_dec.rs2_addr = i_fetch.instr[24:20];
        o_dec.rd_addr  = rd;
        if (i_valid) begin
            case (opcode)
                OPC_OP: begin
                    o_dec.alu_op = alu_from_funct3(funct3, i_fetch.instr[30]);
                    o_dec.reg_we = (rd != '0);
                end
                OPC_OP_IMM: begin
                    o_dec.imm         = imm_i;
                    o_dec.alu_src_imm = 1'b1;
                    o_dec.alu_op      = alu_from_funct3(funct3,
                                            (funct3 == F3_SRL_SRA) && i_fetch.instr[30]);
                    o_dec.reg_we      = (rd != '0);
                end
                OPC_LUI: begin
                    o_dec.imm         = imm_u;
                    o_dec.alu_src_imm = 1'b1;
                    o_dec.alu_op      = ALU_PASS_IMM;
                    o_dec.reg_we      = (rd != '0);
                end
                OPC_JAL: begin
                    o_dec.imm     = imm_j;
                    o_dec.is_jump = 1'b1;
                    o_dec.reg_we  = (rd != '0);  // link value written unless rd is x0
                end
                OPC_BRANCH: begin
                    o_dec.imm = imm_b;
                    case (funct3)
                        F3_BEQ:  o_dec.br_cond = BR_EQ;
                        F3_BNE:  o_dec.br_cond = BR_NE;
                        F3_BLT:  o_dec.br_cond = BR_LT;
                        F3_BGE:  o_dec.br_cond = BR_GE;
                        default: o_dec.br_cond = BR_NONE;
                    endcase
                end
                default: ;  // unknown opcodes retire with no write
            endcase
        end
    end

endmodule

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

    import rv_isa_pkg::*;

    // ########################################
    // fetch side input
    // ########################################
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } fetch_t;

    // ########################################
    // decode to execute record
    // ########################################
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;           // already sign extended
        logic [4:0]      rs1_addr;
        logic [4:0]      rs2_addr;
        logic [4:0]      rd_addr;
        alu_op_t         alu_op;
        logic            alu_src_imm;   // operand b comes from imm
        br_cond_t        br_cond;
        logic            is_jump;
        logic            reg_we;        // never set for x0 or unknown opcodes
    } dec_exec_t;

    // ########################################
    // retire record
    // ########################################
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
        logic            we;
    } retire_t;

endpackage

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN = 64;

    // ########################################
    // major opcodes of the supported subset
    // ########################################
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SRL_SRA = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;

    // funct3 for BRANCH, the unsigned forms are not supported
    localparam logic [2:0] F3_BEQ = 3'd0;
    localparam logic [2:0] F3_BNE = 3'd1;
    localparam logic [2:0] F3_BLT = 3'd4;
    localparam logic [2:0] F3_BGE = 3'd5;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_IMM
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE
    } br_cond_t;

endpackage
